// ==== Makefile ====
# Verilator build and run of the rx register block testbench
BUILD := obj_dir
LOG   := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run the testbench, then search $(LOG) for the pass message"
	@echo "  clean  remove $(BUILD) and $(LOG)"
	@echo "  help   list these targets"

test:
	verilator --binary --timing -f list.f --top-module tb_rx_regs -Mdir $(BUILD) -o sim
	-./$(BUILD)/sim > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "All tests passed!" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD) $(LOG)

// ==== list.f ====
+incdir+src
src/rx_regs_pkg.sv
src/cmd_decoder.sv
src/ctrl_regs.sv
src/counter_snapshot.sv
src/rx_regs_top.sv
verification/rx_regs_checker.sv
verification/tb_rx_regs.sv

// ==== src/cmd_decoder.sv ====
/* command decoder
   registers a strobed GPIO word and splits it into opcode and payload */

`timescale 1ns/1ps
`include "rx_regs_defines.svh"

module cmd_decoder import rx_regs_pkg::*; (
  input  logic                    clk,
  input  logic                    i_reset,
  input  logic [`GPIO_WIDTH-1:0]  i_gpio_to_regf,
  output logic                    o_cmd_valid,
  output opcode_e                 o_cmd_opcode,
  output logic [`STROBE_BIT-1:0]  o_cmd_payload
);

  // raw opcode field of the incoming word
  logic [`OPCODE_MSB-`OPCODE_LSB:0] w_opcode_field;
  // field mapped onto the known opcodes
  opcode_e                          w_opcode;

  assign w_opcode_field = i_gpio_to_regf[`OPCODE_MSB:`OPCODE_LSB];

  // unknown codes collapse to OP_NONE
  always_comb begin
    case (w_opcode_field)
      8'd1:    w_opcode = OP_SOFT_RESET;
      8'd2:    w_opcode = OP_RX_ENABLE;
      8'd3:    w_opcode = OP_LOG_SELECT;
      8'd4:    w_opcode = OP_RAM_READ;
      8'd5:    w_opcode = OP_CAPTURE;
      8'd6:    w_opcode = OP_READBACK;
      default: w_opcode = OP_NONE;
    endcase
  end

  // qualifier and opcode
  always_ff @(posedge clk) begin
    if (i_reset) begin
      o_cmd_valid  <= 1'b0;
      o_cmd_opcode <= OP_NONE;
    end else begin
      o_cmd_valid  <= i_gpio_to_regf[`STROBE_BIT];
      // no strobe, no command
      o_cmd_opcode <= i_gpio_to_regf[`STROBE_BIT] ? w_opcode : OP_NONE;
    end
  end

  // payload bits below the strobe
  always_ff @(posedge clk) begin
    o_cmd_payload <= i_gpio_to_regf[`STROBE_BIT-1:0];
  end

endmodule

// ==== src/counter_snapshot.sv ====
/* counter snapshot and readback
   captures the four rx counters and builds the word returned over GPIO */

`timescale 1ns/1ps
`include "rx_regs_defines.svh"

module counter_snapshot import rx_regs_pkg::*; (
  input  logic                    clk,
  input  logic                    i_reset,
  input  logic                    i_capture,
  input  logic                    i_en_readback,
  input  readback_sel_e           i_readback_sel,
  input  logic                    i_en_read_from_ram,
  input  logic [`GPIO_WIDTH-1:0]  i_data_ram_for_read,
  input  logic [`COUNT_WIDTH-1:0] i_accum_err_i,
  input  logic [`COUNT_WIDTH-1:0] i_accum_err_q,
  input  logic [`COUNT_WIDTH-1:0] i_accum_bit_i,
  input  logic [`COUNT_WIDTH-1:0] i_accum_bit_q,
  output logic [`GPIO_WIDTH-1:0]  o_regf_to_gpio
);

  // held copies of the live counters
  logic [`COUNT_WIDTH-1:0] r_err_i;
  logic [`COUNT_WIDTH-1:0] r_err_q;
  logic [`COUNT_WIDTH-1:0] r_bit_i;
  logic [`COUNT_WIDTH-1:0] r_bit_q;
  // selected 32-bit half
  logic [`GPIO_WIDTH-1:0]  w_counter_half;

  // ========================================
  // snapshot
  // ========================================
  // all four load on the same edge
  always_ff @(posedge clk) begin
    if (i_reset) begin
      r_err_i <= '0;
      r_err_q <= '0;
      r_bit_i <= '0;
      r_bit_q <= '0;
    end else if (i_capture) begin
      r_err_i <= i_accum_err_i;
      r_err_q <= i_accum_err_q;
      r_bit_i <= i_accum_bit_i;
      r_bit_q <= i_accum_bit_q;
    end
  end

  // ========================================
  // readback mux
  // ========================================
  always_comb begin
    case (i_readback_sel)
      ERR_I_LO: w_counter_half = r_err_i[`GPIO_WIDTH-1:0];
      ERR_I_HI: w_counter_half = r_err_i[`COUNT_WIDTH-1:`GPIO_WIDTH];
      BIT_I_LO: w_counter_half = r_bit_i[`GPIO_WIDTH-1:0];
      BIT_I_HI: w_counter_half = r_bit_i[`COUNT_WIDTH-1:`GPIO_WIDTH];
      ERR_Q_LO: w_counter_half = r_err_q[`GPIO_WIDTH-1:0];
      ERR_Q_HI: w_counter_half = r_err_q[`COUNT_WIDTH-1:`GPIO_WIDTH];
      BIT_Q_LO: w_counter_half = r_bit_q[`GPIO_WIDTH-1:0];
      default:  w_counter_half = r_bit_q[`COUNT_WIDTH-1:`GPIO_WIDTH];
    endcase
  end

  // RAM data wins, then counters, else zero
  always_comb begin
    if (i_en_read_from_ram) begin
      o_regf_to_gpio = i_data_ram_for_read;
    end else if (i_en_readback) begin
      o_regf_to_gpio = w_counter_half;
    end else begin
      o_regf_to_gpio = '0;
    end
  end

endmodule

// ==== src/ctrl_regs.sv ====
/* control register bank
   applies decoded commands to the rx controls and raises the capture pulse */

`timescale 1ns/1ps
`include "rx_regs_defines.svh"

module ctrl_regs import rx_regs_pkg::*; (
  input  logic                    clk,
  input  logic                    i_reset,
  input  logic                    i_cmd_valid,
  input  opcode_e                 i_cmd_opcode,
  input  logic [`STROBE_BIT-1:0]  i_cmd_payload,
  output logic                    o_rst_soft,
  output logic                    o_en_rx_soft,
  output logic [`SEL_WIDTH-1:0]   o_data_sel_for_log,
  output logic                    o_en_write,
  output logic                    o_en_read_from_ram,
  output logic [`ADDR_WIDTH-1:0]  o_read_adrs,
  output logic                    o_en_readback,
  output readback_sel_e           o_readback_sel,
  output logic                    o_capture
);

  // set by the first capture command
  logic r_armed;

  // ========================================
  // register updates
  // ========================================
  always_ff @(posedge clk) begin
    if (i_reset) begin
      // rx held in soft reset, receiver enabled
      o_rst_soft         <= 1'b1;
      o_en_rx_soft       <= 1'b1;
      o_data_sel_for_log <= '0;
      o_en_write         <= 1'b0;
      o_en_read_from_ram <= 1'b0;
      o_read_adrs        <= '0;
      o_en_readback      <= 1'b0;
      o_readback_sel     <= ERR_I_LO;
      r_armed            <= 1'b0;
      o_capture          <= 1'b0;
    end else begin
      // single cycle pulse by default
      o_capture <= 1'b0;
      if (i_cmd_valid) begin
        // each opcode touches only its own fields
        case (i_cmd_opcode)
          OP_SOFT_RESET: begin
            o_rst_soft <= i_cmd_payload[0];
          end
          OP_RX_ENABLE: begin
            o_en_rx_soft <= i_cmd_payload[0];
          end
          OP_LOG_SELECT: begin
            o_data_sel_for_log <= i_cmd_payload[`SEL_WIDTH-1:0];
            // write enable rides just above the select
            o_en_write         <= i_cmd_payload[`SEL_WIDTH];
          end
          OP_RAM_READ: begin
            o_en_read_from_ram <= i_cmd_payload[`ENABLE_BIT];
            o_read_adrs        <= i_cmd_payload[`ADDR_WIDTH-1:0];
          end
          OP_CAPTURE: begin
            // capture only if armed before this command
            o_capture <= r_armed;
            r_armed   <= i_cmd_payload[0];
          end
          OP_READBACK: begin
            o_readback_sel <= readback_sel_e'(i_cmd_payload[`SEL_WIDTH-1:0]);
            o_en_readback  <= i_cmd_payload[`ENABLE_BIT];
          end
          default: begin
            // OP_NONE leaves everything as is
          end
        endcase
      end
    end
  end

endmodule

// ==== src/rx_regs_defines.svh ====
/* rx register block constants
   command word layout, counter and RAM sizes */

`ifndef RX_REGS_DEFINES_SVH
`define RX_REGS_DEFINES_SVH

// word widths
`define GPIO_WIDTH  32
`define COUNT_WIDTH 64

// logging RAM
`define RAM_DEPTH   32768
`define ADDR_WIDTH  15

// command word fields
`define STROBE_BIT  23
`define OPCODE_MSB  31
`define OPCODE_LSB  24
// enable flag inside the RAM read and readback payloads
`define ENABLE_BIT  16

// log source and readback selects
`define SEL_WIDTH   3

`endif

// ==== src/rx_regs_pkg.sv ====
/* rx register block types
   command opcodes and counter readback selects */

`include "rx_regs_defines.svh"

package rx_regs_pkg;

  // ========================================
  // command opcodes
  // ========================================
  // field sits in bits 31..24 of the GPIO word
  typedef enum logic [`OPCODE_MSB-`OPCODE_LSB:0] {
    OP_NONE       = 8'd0,
    // payload bit 0 drives soft reset
    OP_SOFT_RESET = 8'd1,
    // payload bit 0 drives rx enable
    OP_RX_ENABLE  = 8'd2,
    // log source select and RAM write enable
    OP_LOG_SELECT = 8'd3,
    // RAM read enable and address
    OP_RAM_READ   = 8'd4,
    // arm, then capture counters
    OP_CAPTURE    = 8'd5,
    // counter half select and readback enable
    OP_READBACK   = 8'd6
  } opcode_e;

  // ========================================
  // counter readback select
  // ========================================
  // I branch first, then Q; low half before high
  typedef enum logic [`SEL_WIDTH-1:0] {
    ERR_I_LO = 3'd0,
    ERR_I_HI = 3'd1,
    BIT_I_LO = 3'd2,
    BIT_I_HI = 3'd3,
    ERR_Q_LO = 3'd4,
    ERR_Q_HI = 3'd5,
    BIT_Q_LO = 3'd6,
    BIT_Q_HI = 3'd7
  } readback_sel_e;

endpackage

// ==== src/rx_regs_top.sv ====
/* rx control and status register block
   GPIO command decode, control bank and counter readback */

`timescale 1ns/1ps
`include "rx_regs_defines.svh"

module rx_regs_top import rx_regs_pkg::*; (
  input  logic                    clk,
  input  logic                    i_reset,
  input  logic [`GPIO_WIDTH-1:0]  i_gpio_to_regf,
  input  logic [`COUNT_WIDTH-1:0] i_accum_err_i,
  input  logic [`COUNT_WIDTH-1:0] i_accum_err_q,
  input  logic [`COUNT_WIDTH-1:0] i_accum_bit_i,
  input  logic [`COUNT_WIDTH-1:0] i_accum_bit_q,
  input  logic [`GPIO_WIDTH-1:0]  i_data_ram_for_read,
  output logic [`GPIO_WIDTH-1:0]  o_regf_to_gpio,
  output logic                    o_rst_soft,
  output logic                    o_en_rx_soft,
  output logic [`SEL_WIDTH-1:0]   o_data_sel_for_log,
  output logic                    o_en_write,
  output logic                    o_en_read_from_ram,
  output logic [`ADDR_WIDTH-1:0]  o_read_adrs
);

  // decoder to control bank
  logic                   w_cmd_valid;
  opcode_e                w_cmd_opcode;
  logic [`STROBE_BIT-1:0] w_cmd_payload;
  // control bank to snapshot
  logic                   w_capture;
  logic                   w_en_readback;
  readback_sel_e          w_readback_sel;

  // command register stage
  cmd_decoder u_cmd_decoder (
    .clk            (clk),
    .i_reset        (i_reset),
    .i_gpio_to_regf (i_gpio_to_regf),
    .o_cmd_valid    (w_cmd_valid),
    .o_cmd_opcode   (w_cmd_opcode),
    .o_cmd_payload  (w_cmd_payload)
  );

  // control field stage
  ctrl_regs u_ctrl_regs (
    .clk                (clk),
    .i_reset            (i_reset),
    .i_cmd_valid        (w_cmd_valid),
    .i_cmd_opcode       (w_cmd_opcode),
    .i_cmd_payload      (w_cmd_payload),
    .o_rst_soft         (o_rst_soft),
    .o_en_rx_soft       (o_en_rx_soft),
    .o_data_sel_for_log (o_data_sel_for_log),
    .o_en_write         (o_en_write),
    .o_en_read_from_ram (o_en_read_from_ram),
    .o_read_adrs        (o_read_adrs),
    .o_en_readback      (w_en_readback),
    .o_readback_sel     (w_readback_sel),
    .o_capture          (w_capture)
  );

  // counter capture and readback word stage
  counter_snapshot u_counter_snapshot (
    .clk                 (clk),
    .i_reset             (i_reset),
    .i_capture           (w_capture),
    .i_en_readback       (w_en_readback),
    .i_readback_sel      (w_readback_sel),
    .i_en_read_from_ram  (o_en_read_from_ram),
    .i_data_ram_for_read (i_data_ram_for_read),
    .i_accum_err_i       (i_accum_err_i),
    .i_accum_err_q       (i_accum_err_q),
    .i_accum_bit_i       (i_accum_bit_i),
    .i_accum_bit_q       (i_accum_bit_q),
    .o_regf_to_gpio      (o_regf_to_gpio)
  );

endmodule

// ==== verification/rx_regs_checker.sv ====
/* rx register block checker
   samples the DUT outputs on request and compares them with the expected row */

`timescale 1ns/1ps
`include "rx_regs_defines.svh"

module rx_regs_checker #(
  parameter int NAME_BITS = 160
) (
  input  logic                    clk,
  input  logic                    i_reset,
  input  logic                    i_check,
  input  logic [NAME_BITS-1:0]    i_name,
  input  logic [21:0]             i_exp_ctrl,
  input  logic [`GPIO_WIDTH-1:0]  i_exp_gpio,
  input  logic [`GPIO_WIDTH-1:0]  i_regf_to_gpio,
  input  logic                    i_rst_soft,
  input  logic                    i_en_rx_soft,
  input  logic [`SEL_WIDTH-1:0]   i_data_sel_for_log,
  input  logic                    i_en_write,
  input  logic                    i_en_read_from_ram,
  input  logic [`ADDR_WIDTH-1:0]  i_read_adrs,
  output int                      o_pass_count,
  output int                      o_fail_count
);

  // control outputs in the same order as the expected word
  logic [21:0] w_ctrl;

  assign w_ctrl = {i_rst_soft, i_en_rx_soft, i_data_sel_for_log, i_en_write,
                   i_en_read_from_ram, i_read_adrs};

  // ========================================
  // compare on request
  // ========================================
  // outputs are settled by the check cycle
  always @(posedge clk) begin
    if (i_reset) begin
      o_pass_count <= 0;
      o_fail_count <= 0;
    end else if (i_check) begin
      if (w_ctrl !== i_exp_ctrl || i_regf_to_gpio !== i_exp_gpio) begin
        $display("MISMATCH %0s: expected ctrl=%h gpio=%h, actual ctrl=%h gpio=%h",
                 i_name, i_exp_ctrl, i_exp_gpio, w_ctrl, i_regf_to_gpio);
        o_fail_count <= o_fail_count + 1;
      end else begin
        $display("pass %0s: ctrl=%h gpio=%h", i_name, w_ctrl, i_regf_to_gpio);
        o_pass_count <= o_pass_count + 1;
      end
    end
  end

endmodule

// ==== verification/tb_rx_regs.sv ====
/* rx register block testbench
   builds a table of commands with expected outputs and applies it row by row */

`timescale 1ns/1ps
`include "rx_regs_defines.svh"

module tb_rx_regs import rx_regs_pkg::*; ();

  localparam int N_ROWS     = 24;
  localparam int NAME_BITS  = 8 * 20;
  // 4 cycles per row, reset, some slack
  localparam int MAX_CYCLES = N_ROWS * 4 + 4 + 20;

  logic clk;
  logic i_reset;
  logic [`GPIO_WIDTH-1:0]  i_gpio_to_regf;
  logic [`COUNT_WIDTH-1:0] i_accum_err_i, i_accum_err_q, i_accum_bit_i, i_accum_bit_q;
  logic [`GPIO_WIDTH-1:0]  i_data_ram_for_read;
  logic [`GPIO_WIDTH-1:0]  o_regf_to_gpio;
  logic o_rst_soft, o_en_rx_soft, o_en_write, o_en_read_from_ram;
  logic [`SEL_WIDTH-1:0]   o_data_sel_for_log;
  logic [`ADDR_WIDTH-1:0]  o_read_adrs;

  // ========================================
  // stimulus table
  // ========================================
  logic [NAME_BITS-1:0]    t_name [N_ROWS];
  logic [`GPIO_WIDTH-1:0]  t_cmd [N_ROWS];
  logic [`GPIO_WIDTH-1:0]  t_ram [N_ROWS];
  // live counters per row in err_i, bit_i, err_q, bit_q order
  logic [`COUNT_WIDTH-1:0] t_cnt [N_ROWS][4];
  logic [21:0]             t_ctrl [N_ROWS];
  logic [`GPIO_WIDTH-1:0]  t_gpio [N_ROWS];
  int n_rows;
  integer seed;

  // reference register state
  logic m_rst, m_en_rx, m_en_write, m_en_ram, m_en_rb, m_armed;
  logic [2:0]              m_log_sel, m_rb_sel;
  logic [14:0]             m_adrs;
  logic [`COUNT_WIDTH-1:0] m_snap [4];

  // checker request
  logic check_req;
  logic [NAME_BITS-1:0]   check_name;
  logic [21:0]            exp_ctrl;
  logic [`GPIO_WIDTH-1:0] exp_gpio;
  int pass_count, fail_count;
  int cycle_count = 0;
  int r;

  rx_regs_top u_rx_regs_top (.*);

  rx_regs_checker #(.NAME_BITS(NAME_BITS)) u_rx_regs_checker (
    .clk(clk), .i_reset(i_reset), .i_check(check_req), .i_name(check_name),
    .i_exp_ctrl(exp_ctrl), .i_exp_gpio(exp_gpio), .i_regf_to_gpio(o_regf_to_gpio),
    .i_rst_soft(o_rst_soft), .i_en_rx_soft(o_en_rx_soft),
    .i_data_sel_for_log(o_data_sel_for_log), .i_en_write(o_en_write),
    .i_en_read_from_ram(o_en_read_from_ram), .i_read_adrs(o_read_adrs),
    .o_pass_count(pass_count), .o_fail_count(fail_count)
  );

  always #20 clk = ~clk;

  // run limit
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= MAX_CYCLES) begin
      $display("run timed out after %0d cycles before all rows were checked", cycle_count);
      $display("Test failures found");
      $finish;
    end
  end

  // opcode, strobe, payload
  function automatic logic [31:0] build_command(input logic [7:0] op,
                                                input logic [22:0] payload);
    return {op, 1'b1, payload};
  endfunction

  // append a row and advance the reference model
  task automatic add_row(input string name, input logic [31:0] cmd);
    logic [22:0] pl;
    int k;
    pl = cmd[22:0];
    $sformat(t_name[n_rows], "%s", name);
    t_cmd[n_rows] = cmd;
    t_ram[n_rows] = $random(seed);
    for (k = 0; k < 4; k++) begin
      t_cnt[n_rows][k] = {$random(seed), $random(seed)};
    end
    if (cmd[23]) begin
      case (cmd[31:24])
        OP_SOFT_RESET: m_rst = pl[0];
        OP_RX_ENABLE:  m_en_rx = pl[0];
        OP_LOG_SELECT: {m_en_write, m_log_sel} = pl[3:0];
        OP_RAM_READ:   {m_en_ram, m_adrs} = {pl[`ENABLE_BIT], pl[14:0]};
        OP_READBACK:   {m_en_rb, m_rb_sel} = {pl[`ENABLE_BIT], pl[2:0]};
        OP_CAPTURE: begin
          // armed by an earlier capture command
          if (m_armed) m_snap = t_cnt[n_rows];
          m_armed = pl[0];
        end
        default: ;
      endcase
    end
    t_ctrl[n_rows] = {m_rst, m_en_rx, m_log_sel, m_en_write, m_en_ram, m_adrs};
    // RAM first, then the chosen counter half
    if (m_en_ram) t_gpio[n_rows] = t_ram[n_rows];
    else if (m_en_rb) t_gpio[n_rows] = m_rb_sel[0] ? m_snap[m_rb_sel[2:1]][63:32]
                                                   : m_snap[m_rb_sel[2:1]][31:0];
    else t_gpio[n_rows] = '0;
    n_rows++;
  endtask

  task automatic build_table();
    int s;
    {m_rst, m_en_rx, m_en_write, m_en_ram, m_en_rb, m_armed} = 6'b110000;
    {m_log_sel, m_rb_sel, m_adrs} = '0;
    m_snap = '{default: '0};
    add_row("reset_values", 32'h0);
    add_row("soft_reset_clear", build_command(OP_SOFT_RESET, 23'd0));
    add_row("rx_enable_clear", build_command(OP_RX_ENABLE, 23'd0));
    add_row("log_select", build_command(OP_LOG_SELECT, 23'h00000d));
    add_row("strobe_low", {8'd2, 1'b0, 23'd1});
    add_row("bad_opcode", build_command(8'h07, 23'h7fffff));
    add_row("ram_read", build_command(OP_RAM_READ, 23'h012a5c));
    add_row("ram_over_counters", build_command(OP_READBACK, 23'h010000));
    add_row("ram_read_off", build_command(OP_RAM_READ, 23'd0));
    add_row("capture_arm", build_command(OP_CAPTURE, 23'd1));
    add_row("capture_take", build_command(OP_CAPTURE, 23'd1));
    add_row("counters_hold", 32'h0);
    for (s = 0; s < 8; s++) begin
      add_row($sformatf("readback_sel%0d", s), build_command(OP_READBACK, 23'h010000 | 23'(s)));
    end
    add_row("readback_off", build_command(OP_READBACK, 23'd3));
    add_row("soft_reset_set", build_command(OP_SOFT_RESET, 23'd1));
    add_row("rx_enable_set", build_command(OP_RX_ENABLE, 23'd1));
    add_row("log_select_clear", build_command(OP_LOG_SELECT, 23'd0));
  endtask

  // one strobed cycle, idle cycles, check on the last
  task automatic apply_row(input int idx);
    i_gpio_to_regf = t_cmd[idx];
    i_data_ram_for_read = t_ram[idx];
    {i_accum_err_i, i_accum_bit_i} = {t_cnt[idx][0], t_cnt[idx][1]};
    {i_accum_err_q, i_accum_bit_q} = {t_cnt[idx][2], t_cnt[idx][3]};
    @(negedge clk);
    i_gpio_to_regf = '0;
    repeat (2) @(negedge clk);
    {check_name, exp_ctrl, exp_gpio} = {t_name[idx], t_ctrl[idx], t_gpio[idx]};
    check_req = 1'b1;
    @(negedge clk);
    check_req = 1'b0;
  endtask

  initial begin
    seed = 32'h72b;
    n_rows = 0;
    {clk, i_reset, check_req} = 3'b010;
    {i_gpio_to_regf, i_data_ram_for_read, check_name, exp_ctrl, exp_gpio} = '0;
    {i_accum_err_i, i_accum_err_q, i_accum_bit_i, i_accum_bit_q} = '0;
    build_table();
    repeat (4) @(negedge clk);
    i_reset = 1'b0;
    for (r = 0; r < n_rows; r++) begin
      apply_row(r);
    end
    $display("rows %0d, passed %0d, failed %0d", n_rows, pass_count, fail_count);
    if (fail_count == 0 && pass_count == n_rows) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule
